/* Bender.yml */
package:
  name: rv32e_core

sources:
  - src/cpu_pkg.sv
  - src/idu.sv
  - src/ifu.sv
  - src/gpr_file.sv
  - src/exu.sv
  - src/lsu.sv
  - src/mem_arbiter.sv
  - src/cpu_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/cpu_props.sv
      - verification/tb_cpu.sv

/* build.f */
src/cpu_pkg.sv
src/idu.sv
src/ifu.sv
src/gpr_file.sv
src/exu.sv
src/lsu.sv
src/mem_arbiter.sv
src/cpu_top.sv
verification/tb_clock.sv
verification/cpu_props.sv
verification/tb_cpu.sv

/* src/cpu_pkg.sv */
package cpu_pkg;

    // One transaction on the shared memory bus
    typedef struct packed {
        logic [31:0] addr;                  // Word aligned
        logic [31:0] wdata;
        logic [3:0]  wstrb;                 // One bit per byte lane
        logic        we;
    } mem_req_t;

    typedef enum logic [1:0] {
        alu_none     = 2'b00,
        alu_add      = 2'b01,               // Operand 1 plus operand 2
        alu_pass_imm = 2'b10                // Used by lui
    } alu_op_e;

    typedef struct packed {
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [3:0]  rd;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        gpr_we;
        logic        load;
        logic        store;
        logic        byte_access;
        logic        word_access;
        logic        src2_is_imm;
        logic        is_jump;               // Only jalr
        logic        is_end;                // ebreak
        logic        illegal;
    } decode_t;

endpackage

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic        clock,
    input  logic        reset,
    output logic        mem_req,
    output mem_req_t    mem_req_data,
    input  logic        mem_ack,
    input  logic [31:0] mem_rdata,
    output logic        halted,
    output logic        illegal
);

    logic        fetch_req;
    mem_req_t    fetch_data;
    logic        fetch_ack;
    logic        lsu_req;
    mem_req_t    lsu_data;
    logic        lsu_ack;
    logic        fetch_start;
    logic        pc_update;
    logic [31:0] next_pc;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        inst_valid;
    decode_t     dec;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        gpr_we;
    logic [31:0] gpr_wdata;
    logic        mem_start;
    logic [31:0] alu_result;
    logic        lsu_done;
    logic [31:0] load_data;

    ifu #(
        .reset_pc(reset_pc)
    ) i_ifu (
        .clock, .reset, .fetch_start, .next_pc, .pc_update, .pc, .inst, .inst_valid,
        .fetch_req, .fetch_data, .fetch_ack, .rdata(mem_rdata)
    );

    idu i_idu (
        .inst, .dec
    );

    gpr_file i_gpr_file (
        .clock, .reset, .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .we(gpr_we), .wdata(gpr_wdata), .rdata1, .rdata2
    );

    exu i_exu (
        .clock, .reset, .dec, .inst_valid, .pc, .rdata1, .rdata2, .lsu_done, .load_data,
        .gpr_we, .gpr_wdata, .next_pc, .pc_update, .fetch_start, .mem_start, .alu_result,
        .halted, .illegal
    );

    lsu i_lsu (
        .clock, .reset, .start(mem_start), .dec, .addr(alu_result), .store_data(rdata2),
        .mem_req(lsu_req), .mem_data(lsu_data), .mem_ack(lsu_ack), .rdata(mem_rdata),
        .done(lsu_done), .load_data
    );

    mem_arbiter i_mem_arbiter (
        .clock, .reset,
        .ifu_req(fetch_req), .ifu_data(fetch_data), .ifu_ack(fetch_ack),
        .lsu_req, .lsu_data, .lsu_ack,
        .bus_req(mem_req), .bus_data(mem_req_data), .bus_ack(mem_ack)
    );

endmodule

/* src/exu.sv */
`timescale 1ns/1ps

module exu import cpu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  decode_t     dec,
    input  logic        inst_valid,
    input  logic [31:0] pc,
    input  logic [31:0] rdata1,
    input  logic [31:0] rdata2,
    input  logic        lsu_done,
    input  logic [31:0] load_data,
    output logic        gpr_we,
    output logic [31:0] gpr_wdata,
    output logic [31:0] next_pc,
    output logic        pc_update,
    output logic        fetch_start,
    output logic        mem_start,
    output logic [31:0] alu_result,
    output logic        halted,
    output logic        illegal
);

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_halt
    } state_e;

    state_e      state;
    logic        reset_q;
    logic        executing;
    logic        mem_op;
    logic        stop;
    logic        mem_finish;
    logic [31:0] operand2;
    logic [31:0] sum;
    logic [31:0] pc_plus4;

    assign executing  = (state == st_execute);
    assign mem_op     = dec.load | dec.store;
    assign stop       = dec.is_end | dec.illegal;
    assign mem_finish = lsu_done & ((state == st_memory) | (executing & mem_op));
    assign operand2   = dec.src2_is_imm ? dec.imm : rdata2;
    assign sum        = rdata1 + operand2;
    assign pc_plus4   = pc + 32'd4;

    always_comb begin
        case (dec.alu_op)
            alu_add:      alu_result = sum;
            alu_pass_imm: alu_result = dec.imm;
            default:      alu_result = 32'h0;
        endcase
    end

    assign next_pc     = dec.is_jump ? {sum[31:1], 1'b0} : pc_plus4;
    assign gpr_wdata   = dec.load ? load_data : (dec.is_jump ? pc_plus4 : alu_result);
    assign pc_update   = (executing & ~mem_op & ~stop) | mem_finish;
    assign gpr_we      = dec.gpr_we & pc_update;  // Loads write at the ack edge
    assign mem_start   = executing & mem_op;
    assign fetch_start = pc_update | reset_q;     // First fetch once reset is released

    always_ff @(posedge clock) begin
        reset_q <= reset;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_fetch;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (inst_valid) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (stop) begin
                        state   <= st_halt;
                        halted  <= 1'b1;
                        illegal <= dec.illegal;      // Sticky until the next reset
                    end else if (mem_op & ~lsu_done) begin
                        state <= st_memory;
                    end else begin
                        state <= st_fetch;
                    end
                end
                st_memory: begin
                    if (lsu_done) begin
                        state <= st_fetch;
                    end
                end
                default: state <= st_halt;
            endcase
        end
    end

endmodule

/* src/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
    input  logic        clock,
    input  logic        reset,
    input  logic [3:0]  rs1,
    input  logic [3:0]  rs2,
    input  logic [3:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [16];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (we && (rd != 4'd0)) begin
            regs[rd] <= wdata;                // x0 is never written so it reads zero
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

/* src/idu.sv */
`timescale 1ns/1ps

module idu import cpu_pkg::*; (
    input  logic [31:0] inst,
    output decode_t     dec
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    logic        inst_add;
    logic        inst_addi;
    logic        inst_jalr;
    logic        inst_lbu;
    logic        inst_lw;
    logic        inst_sb;
    logic        inst_sw;
    logic        inst_lui;
    logic        inst_ebreak;
    logic        inst_zero;
    logic        type_r;
    logic        type_i;
    logic        type_s;
    logic        type_u;
    logic        type_n;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};

    assign inst_add    = (opcode == 7'h33) & (funct3 == 3'h0) & (funct7 == 7'h00);
    assign inst_addi   = (opcode == 7'h13) & (funct3 == 3'h0);
    assign inst_jalr   = (opcode == 7'h67) & (funct3 == 3'h0);
    assign inst_lbu    = (opcode == 7'h03) & (funct3 == 3'h4);
    assign inst_lw     = (opcode == 7'h03) & (funct3 == 3'h2);
    assign inst_sb     = (opcode == 7'h23) & (funct3 == 3'h0);
    assign inst_sw     = (opcode == 7'h23) & (funct3 == 3'h2);
    assign inst_lui    = (opcode == 7'h37);
    assign inst_ebreak = (inst == 32'h0010_0073);
    assign inst_zero   = (inst == 32'h0000_0000);    // Executes as a no-operation

    assign type_r = inst_add;
    assign type_i = inst_addi | inst_jalr | inst_lw | inst_lbu;
    assign type_s = inst_sw | inst_sb;
    assign type_u = inst_lui;
    assign type_n = inst_ebreak | inst_zero;

    always_comb begin
        dec.rs1 = rs1[3:0];                           // RV32E has 16 registers
        dec.rs2 = rs2[3:0];
        dec.rd  = rd[3:0];
        dec.imm = ({32{type_i}} & imm_i)
                | ({32{type_s}} & imm_s)
                | ({32{type_u}} & imm_u);
        if (inst_lui) begin
            dec.alu_op = alu_pass_imm;
        end else if (type_r | type_i | type_s) begin
            dec.alu_op = alu_add;                     // Also forms addresses and jalr targets
        end else begin
            dec.alu_op = alu_none;
        end
        dec.gpr_we      = type_r | type_i | type_u;
        dec.load        = inst_lw | inst_lbu;
        dec.store       = inst_sw | inst_sb;
        dec.byte_access = inst_lbu | inst_sb;
        dec.word_access = inst_lw | inst_sw;
        dec.src2_is_imm = type_i | type_s | type_u;
        dec.is_jump     = inst_jalr;
        dec.is_end      = inst_ebreak;
        dec.illegal     = ~(type_r | type_i | type_s | type_u | type_n);
    end

endmodule

/* src/ifu.sv */
`timescale 1ns/1ps

module ifu import cpu_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        fetch_start,
    input  logic [31:0] next_pc,
    input  logic        pc_update,
    output logic [31:0] pc,
    output logic [31:0] inst,
    output logic        inst_valid,
    output logic        fetch_req,
    output mem_req_t    fetch_data,
    input  logic        fetch_ack,
    input  logic [31:0] rdata
);

    always_ff @(posedge clock) begin
        if (reset) begin
            pc         <= reset_pc;
            fetch_req  <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            if (pc_update) begin
                pc <= next_pc;
            end
            if (fetch_ack) begin
                fetch_req <= 1'b0;                // Request drops after the ack cycle
            end else if (fetch_start) begin
                fetch_req <= 1'b1;
            end
            inst_valid <= fetch_req & fetch_ack;
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_req & fetch_ack) begin
            inst <= rdata;
        end
    end

    always_comb begin
        fetch_data.addr  = pc;                    // Read only, never writes
        fetch_data.wdata = 32'h0;
        fetch_data.wstrb = 4'h0;
        fetch_data.we    = 1'b0;
    end

endmodule

/* src/lsu.sv */
`timescale 1ns/1ps

module lsu import cpu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  decode_t     dec,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,
    output logic        mem_req,
    output mem_req_t    mem_data,
    input  logic        mem_ack,
    input  logic [31:0] rdata,
    output logic        done,
    output logic [31:0] load_data
);

    logic        busy;
    logic [3:0]  byte_strb;
    logic [31:0] shifted;

    // Request goes out in the start cycle and is held by busy until the ack
    assign mem_req = start | busy;
    assign done    = mem_req & mem_ack;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (mem_ack) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end
    end

    assign byte_strb = 4'b0001 << addr[1:0];

    always_comb begin
        mem_data.addr = {addr[31:2], 2'b00};
        if (dec.byte_access) begin
            mem_data.wdata = {4{store_data[7:0]}};   // Memory picks the lane by wstrb
        end else begin
            mem_data.wdata = store_data;
        end
        if (!dec.store) begin
            mem_data.wstrb = 4'b0000;
        end else if (dec.word_access) begin
            mem_data.wstrb = 4'b1111;
        end else begin
            mem_data.wstrb = byte_strb;
        end
        mem_data.we = dec.store;
    end

    assign shifted   = rdata >> {addr[1:0], 3'b000};
    assign load_data = dec.byte_access ? {24'h0, shifted[7:0]} : rdata;

endmodule

/* src/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import cpu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     ifu_req,
    input  mem_req_t ifu_data,
    output logic     ifu_ack,
    input  logic     lsu_req,
    input  mem_req_t lsu_data,
    output logic     lsu_ack,
    output logic     bus_req,
    output mem_req_t bus_data,
    input  logic     bus_ack
);

    logic locked;
    logic owner_lsu;
    logic grant_lsu;

    // The lsu wins when the bus is idle; a running transaction keeps its owner
    assign grant_lsu = locked ? owner_lsu : lsu_req;

    assign bus_req  = grant_lsu ? lsu_req : ifu_req;
    assign bus_data = grant_lsu ? lsu_data : ifu_data;
    assign lsu_ack  = bus_ack & bus_req & grant_lsu;
    assign ifu_ack  = bus_ack & bus_req & ~grant_lsu;

    always_ff @(posedge clock) begin
        if (reset) begin
            locked    <= 1'b0;
            owner_lsu <= 1'b0;
        end else if (bus_req & bus_ack) begin
            locked <= 1'b0;                     // Bus is free again after the ack
        end else if (bus_req) begin
            locked    <= 1'b1;
            owner_lsu <= grant_lsu;
        end
    end

endmodule

/* verification/cpu_props.sv */
`timescale 1ns/1ps

module cpu_props import cpu_pkg::*; (
    input logic     clock,
    input logic     reset,
    input logic     mem_req,
    input mem_req_t mem_req_data,
    input logic     mem_ack,
    input logic     halted
);

    int   failures = 0;
    logic reset_q  = 1'b0;

    always_ff @(posedge clock) begin
        reset_q <= reset;
    end

    request_held: assert property (@(posedge clock) disable iff (reset)
        mem_req && !mem_ack |=> mem_req && $stable(mem_req_data)) else begin
        failures++;
        $error("memory request dropped or changed before its ack");
    end

    // Only a reset may clear halted
    halt_sticky: assert property (@(posedge clock)
        halted && !reset |=> halted) else begin
        failures++;
        $error("halted fell without a reset");
    end

    quiet_after_halt: assert property (@(posedge clock) disable iff (reset)
        halted |-> !mem_req) else begin
        failures++;
        $error("memory request issued while halted");
    end

    quiet_in_reset: assert property (@(posedge clock)
        reset && reset_q |-> !mem_req) else begin
        failures++;
        $error("memory request high during reset");
    end

endmodule

bind cpu_top cpu_props i_cpu_props (
    .clock(clock),
    .reset(reset),
    .mem_req(mem_req),
    .mem_req_data(mem_req_data),
    .mem_ack(mem_ack),
    .halted(halted)
);

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;                  // 10 ns period
        end
    end

endmodule

/* verification/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam logic [31:0] reset_pc    = 32'h0000_0080;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;
    localparam logic [31:0] sub_word    = 32'h4020_80b3;    // sub x1, x1, x2 is not supported
    localparam int          halt_limit  = 2000;

    logic        clock;
    logic        reset;
    logic        mem_req;
    mem_req_t    mem_req_data;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        halted;
    logic        illegal;

    logic [31:0] mem [256];                                 // Word indexed by addr[9:2]
    logic [31:0] lfsr = 32'd82171;
    logic [31:0] load_addr;
    logic [31:0] req_addrs [$];
    logic        req_writes [$];
    logic        pending;
    int          wait_left;

    tb_clock i_tb_clock (.clock);

    cpu_top #(.reset_pc(reset_pc)) i_cpu_top (
        .clock, .reset, .mem_req, .mem_req_data, .mem_ack, .mem_rdata, .halted, .illegal
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return 32'hc3a5_0000 ^ addr;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] value);
        return {{20{value[11]}}, value};
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return mem[addr[9:2]];
    endfunction

    function automatic logic [31:0] add(input logic [4:0] rd, rs1, rs2);
        return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] jalr(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h67};
    endfunction

    function automatic logic [31:0] lbu(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b100, rd, 7'h03};
    endfunction

    function automatic logic [31:0] sb(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'h37};
    endfunction

    // Memory that acks each request after 1 to 4 cycles drawn from two LFSR bits
    always @(posedge clock) begin
        logic [1:0] bits;
        int         index;
        if (reset) begin
            mem_ack <= 1'b0;
            pending = 1'b0;
        end else if (mem_ack) begin
            mem_ack <= 1'b0;
        end else if (mem_req) begin
            if (!pending) begin
                req_addrs.push_back(mem_req_data.addr);
                req_writes.push_back(mem_req_data.we);
                for (int b = 0; b < 2; b++) begin
                    lfsr = lfsr_step(lfsr);
                    bits[b] = lfsr[0];
                end
                wait_left = bits + 1;
            end
            if (wait_left == 1) begin
                index = mem_req_data.addr[9:2];
                if (mem_req_data.we) begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (mem_req_data.wstrb[lane]) begin
                            mem[index][8*lane +: 8] = mem_req_data.wdata[8*lane +: 8];
                        end
                    end
                end
                mem_rdata <= mem[index];
                mem_ack   <= 1'b1;
                pending = 1'b0;
            end else begin
                wait_left = wait_left - 1;
                pending = 1'b1;
            end
        end
    end

    task automatic check_value(input logic [31:0] actual, expected, input string what);
        if (actual !== expected) begin
            $display("error %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic emit(input logic [31:0] word);
        mem[load_addr[9:2]] = word;
        load_addr = load_addr + 32'd4;
    endtask

    task automatic hold_reset();
        @(posedge clock);
        reset <= 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i * 4);
        end
        req_addrs.delete();
        req_writes.delete();
        load_addr = reset_pc;
    endtask

    task automatic release_reset();
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value(halted, 1'b0, "halted after reset");
        check_value(illegal, 1'b0, "illegal after reset");
    endtask

    task automatic wait_for_halt();
        int cycles;
        int count;
        cycles = 0;
        while (!halted && cycles < halt_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: the core did not halt within %0d cycles", halt_limit);
            $display("Test failed");
            $fatal(1, "halt timeout");
        end
        count = req_addrs.size();
        for (int i = 0; i < 8; i++) begin
            @(negedge clock);
            check_value(mem_req, 1'b0, "memory request after halt");
        end
        check_value(req_addrs.size(), count, "request count after halt");
    endtask

    task automatic halt_conditions();
        hold_reset();
        emit(32'h0000_0000);
        emit(addi(1, 0, 12'h02a));
        emit(sw(1, 0, 12'h200));
        emit(ebreak_word);
        release_reset();
        wait_for_halt();
        check_value(illegal, 1'b0, "illegal after ebreak");
        check_value(word_at(32'h200), 32'h2a, "word stored after the zero word");
        check_value(req_addrs.size(), 5, "requests up to ebreak");
        check_value(req_addrs[4], reset_pc + 32'd12, "ebreak fetch address");
        hold_reset();
        emit(sub_word);
        emit(addi(1, 0, 12'h001));
        release_reset();
        wait_for_halt();
        check_value(illegal, 1'b1, "illegal after an unsupported word");
        check_value(req_addrs.size(), 1, "requests up to the unsupported word");
    endtask

    task automatic reset_and_first_fetch();
        hold_reset();
        emit(addi(1, 0, 12'h005));
        emit(ebreak_word);
        release_reset();
        wait_for_halt();
        check_value(req_addrs.size(), 2, "request count");
        check_value(req_addrs[0], reset_pc, "first fetch address");
        check_value(req_writes[0], 1'b0, "first fetch write enable");
        check_value(req_addrs[1], reset_pc + 32'd4, "second fetch address");
        check_value(illegal, 1'b0, "illegal after ebreak");
    endtask

    task automatic arithmetic_results();
        logic [31:0] upper;
        logic [31:0] sum_pos;
        logic [31:0] all_ones;
        hold_reset();
        emit(lui(1, 20'h12345));
        emit(addi(2, 1, 12'h678));
        emit(addi(3, 0, 12'hfff));
        emit(add(4, 2, 3));
        emit(addi(0, 0, 12'h037));                          // Lands in x0 and is dropped
        emit(addi(7, 2, -12'sd16));
        emit(addi(6, 0, 12'h200));
        emit(sw(1, 6, 12'h000));
        emit(sw(2, 6, 12'h004));
        emit(sw(3, 6, 12'h008));
        emit(sw(4, 6, 12'h00c));
        emit(sw(0, 6, 12'h010));
        emit(sw(7, 6, 12'h014));
        emit(ebreak_word);
        release_reset();
        wait_for_halt();
        upper    = 32'h12345 << 12;
        sum_pos  = upper + sext12(12'h678);
        all_ones = 32'h0 + sext12(12'hfff);
        check_value(illegal, 1'b0, "illegal in arithmetic program");
        check_value(word_at(32'h200), upper, "lui result");
        check_value(word_at(32'h204), sum_pos, "addi result");
        check_value(word_at(32'h208), all_ones, "addi negative result");
        check_value(word_at(32'h20c), sum_pos + all_ones, "add result");
        check_value(word_at(32'h210), 32'h0, "x0 after write");
        check_value(word_at(32'h214), sum_pos + sext12(12'hff0), "addi minus 16 result");
    endtask

    task automatic byte_lanes();
        logic [11:0] value;
        logic [31:0] expected;
        hold_reset();
        emit(addi(1, 0, 12'h240));
        for (int k = 0; k < 4; k++) begin
            value = 12'h1a0 + 12'(k * 17);
            emit(addi(2, 0, value));
            emit(sb(2, 1, 12'(5 * k)));                     // Lane k of word 0x240 + 4k
            emit(lbu(3, 1, 12'(5 * k)));
            emit(sw(3, 1, 12'(64 + 4 * k)));
        end
        emit(ebreak_word);
        release_reset();
        wait_for_halt();
        check_value(illegal, 1'b0, "illegal in byte program");
        for (int k = 0; k < 4; k++) begin
            value = 12'h1a0 + 12'(k * 17);
            expected = fill_word(32'h240 + 4 * k);
            expected[8*k +: 8] = value[7:0];
            check_value(word_at(32'h240 + 4 * k), expected, "word after sb");
            check_value(word_at(32'h280 + 4 * k), {24'h0, value[7:0]}, "lbu result");
        end
    endtask

    task automatic jalr_target_and_link();
        logic [31:0] base;
        base = reset_pc + 32'h20;
        hold_reset();
        emit(addi(1, 0, base[11:0]));
        emit(jalr(5, 1, 12'h001));                          // Odd target whose bit 0 must clear
        emit(ebreak_word);
        load_addr = base;
        emit(addi(6, 0, 12'h200));
        emit(sw(5, 6, 12'h000));
        emit(ebreak_word);
        release_reset();
        wait_for_halt();
        check_value(illegal, 1'b0, "illegal in jalr program");
        check_value(req_addrs.size(), 6, "requests in jalr program");
        check_value(req_addrs[2], (base + 32'd1) & ~32'd1, "fetch after jalr");
        check_value(word_at(32'h200), reset_pc + 32'd4 + 32'd4, "jalr link value");
    endtask

    initial begin
        reset     <= 1'b1;
        mem_ack   <= 1'b0;
        mem_rdata <= 32'h0;
        halt_conditions();
        reset_and_first_fetch();
        arithmetic_results();
        byte_lanes();
        jalr_target_and_link();
        if (i_cpu_top.i_cpu_props.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("bus property assertions failed %0d times",
                     i_cpu_top.i_cpu_props.failures);
            $display("Test failed");
        end
        $finish;
    end

endmodule
